// File: hw/issue_pkg.sv
`default_nettype none

package issue_pkg;

  ////////////////////////////////////////////////////////////////////////
  // widths and field positions
  ////////////////////////////////////////////////////////////////////////

  localparam int inst_width    = 32;
  localparam int addr_width    = 32;
  localparam int iid_width     = 4;
  localparam int reg_idx_width = 5;  // 32 registers.

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;

  typedef logic [inst_width-1:0]    inst_t;
  typedef logic [addr_width-1:0]    addr_t;
  typedef logic [iid_width-1:0]     iid_t;
  typedef logic [reg_idx_width-1:0] reg_idx_t;

  ////////////////////////////////////////////////////////////////////////
  // opcodes grouped by family in the upper two bits
  ////////////////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    op_nop   = 6'h00,  // register alu.
    op_add   = 6'h01,
    op_sub   = 6'h02,
    op_cmp   = 6'h03,
    op_test  = 6'h04,
    op_addi  = 6'h10,  // immediate.
    op_subi  = 6'h11,
    op_cmpi  = 6'h12,
    op_testi = 6'h13,
    op_lw    = 6'h20,  // memory.
    op_sw    = 6'h21,
    op_la    = 6'h22,
    op_sa    = 6'h23,
    op_jmp   = 6'h30,  // branch.
    op_je    = 6'h31,
    op_jr    = 6'h32
  } opcode_t;

  typedef enum logic [1:0] {
    pipe_any    = 2'd0,
    pipe_branch = 2'd1,
    pipe_mem    = 2'd2
  } pipe_t;

endpackage

`default_nettype wire

// File: hw/inst_classify.sv
`timescale 1ns/1ps
`default_nettype none

module inst_classify
  import issue_pkg::*;
(
  input  inst_t    inst,
  output pipe_t    pipe,
  output logic     src_rs_used,
  output logic     src_rt_used,
  output logic     dst_used,
  output reg_idx_t dst_reg
);

  opcode_t    op;
  logic [1:0] family;

  assign op     = opcode_t'(inst[opcode_msb:opcode_lsb]);
  assign family = inst[opcode_msb -: 2];

  always_comb begin
    pipe        = pipe_any;
    src_rs_used = 1'b0;
    src_rt_used = 1'b0;
    dst_used    = 1'b0;
    dst_reg     = inst[rt_msb:rt_lsb];
    case (family)
      2'b00: begin
        if (op != op_nop) begin  // empty slot decodes as nop.
          src_rs_used = 1'b1;
          src_rt_used = 1'b1;
          dst_used    = 1'b1;
          dst_reg     = inst[rd_msb:rd_lsb];
          if (op == op_cmp || op == op_test) begin
            pipe = pipe_branch;  // flags go to the branch pipe.
          end
        end
      end
      2'b01: begin
        src_rs_used = 1'b1;
        dst_used    = 1'b1;
        if (op == op_cmpi || op == op_testi) begin
          pipe = pipe_branch;
        end
      end
      2'b10: begin
        pipe = pipe_mem;
        case (op)
          op_lw: begin
            src_rs_used = 1'b1;
            dst_used    = 1'b1;
          end
          op_sw: begin
            src_rs_used = 1'b1;
            src_rt_used = 1'b1;
          end
          op_la:   dst_used    = 1'b1;
          op_sa:   src_rt_used = 1'b1;
          default: ;
        endcase
      end
      default: begin
        pipe        = pipe_branch;
        src_rs_used = (op == op_jr);  // register target.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/load_use_check.sv
`timescale 1ns/1ps
`default_nettype none

module load_use_check
  import issue_pkg::*;
(
  input  inst_t      load_inst,
  input  reg_idx_t   rs0,
  input  reg_idx_t   rt0,
  input  reg_idx_t   rs1,
  input  reg_idx_t   rt1,
  input  logic       src_rs_used0,
  input  logic       src_rt_used0,
  input  logic       src_rs_used1,
  input  logic       src_rt_used1,
  output logic       load_stall,
  output logic [1:0] mask
);

  reg_idx_t load_rt;
  logic     load_valid;
  logic     hit0;
  logic     hit1;

  assign load_rt    = load_inst[rt_msb:rt_lsb];
  assign load_valid = |load_inst;

  // any used source of either slot.
  assign hit0 = (src_rs_used0 && rs0 == load_rt) || (src_rt_used0 && rt0 == load_rt);
  assign hit1 = (src_rs_used1 && rs1 == load_rt) || (src_rt_used1 && rt1 == load_rt);

  assign load_stall = load_valid && (hit0 || hit1);
  assign mask       = load_stall ? 2'b00 : 2'b11;  // whole pair waits.

endmodule

`default_nettype wire

// File: hw/pair_dep_check.sv
`timescale 1ns/1ps
`default_nettype none

module pair_dep_check
  import issue_pkg::*;
(
  input  logic [1:0] mask_in,
  input  logic       dst_used0,
  input  reg_idx_t   dst_reg0,
  input  reg_idx_t   rs1,
  input  reg_idx_t   rt1,
  input  logic       src_rs_used1,
  input  logic       src_rt_used1,
  output logic [1:0] mask_out
);

  logic both_valid;
  logic rs_hit;
  logic rt_hit;
  logic raw;

  assign both_valid = mask_in[0] && mask_in[1];

  assign rs_hit = src_rs_used1 && (rs1 == dst_reg0);
  assign rt_hit = src_rt_used1 && (rt1 == dst_reg0);

  // slot 1 reads what slot 0 writes in the same cycle.
  assign raw = both_valid && dst_used0 && (rs_hit || rt_hit);

  always_comb begin
    if (raw) begin
      mask_out = mask_in & 2'b01;  // hold slot 1.
    end else begin
      mask_out = mask_in;
    end
  end

endmodule

`default_nettype wire

// File: hw/pipe_steer.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_steer
  import issue_pkg::*;
(
  input  logic [1:0] mask_in,
  input  pipe_t      pipe0,
  input  pipe_t      pipe1,
  output logic [1:0] mask_out,
  output logic       swap
);

  pipe_t p0;
  pipe_t p1;

  // masked slots place no demand on a pipe.
  assign p0 = mask_in[0] ? pipe0 : pipe_any;
  assign p1 = mask_in[1] ? pipe1 : pipe_any;

  always_comb begin
    mask_out = mask_in;
    swap     = 1'b0;
    case ({p0, p1})
      {pipe_branch, pipe_branch}: begin
        mask_out = mask_in & 2'b01;  // one branch pipe.
      end
      {pipe_mem, pipe_mem}: begin
        mask_out = mask_in & 2'b01;
        swap     = 1'b1;  // slot 0 to the memory port.
      end
      {pipe_mem, pipe_any},
      {pipe_mem, pipe_branch},
      {pipe_any, pipe_branch}: begin
        swap = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage
  import issue_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  flush,
  input  inst_t inst0,
  input  inst_t inst1,
  input  addr_t pc0,
  input  addr_t pc1,
  input  iid_t  id0,
  input  iid_t  id1,
  output logic  stall,
  output inst_t out_inst0,
  output inst_t out_inst1,
  output addr_t out_pc0,
  output addr_t out_pc1,
  output iid_t  out_id0,
  output iid_t  out_id1
);

  inst_t      hold_inst0, hold_inst1;
  addr_t      hold_pc0, hold_pc1;
  iid_t       hold_id0, hold_id1;
  inst_t      last_load;
  inst_t      sel_inst0, sel_inst1;
  addr_t      sel_pc0, sel_pc1;
  iid_t       sel_id0, sel_id1;
  pipe_t      pipe0, pipe1, ld_pipe;
  logic       rs_used0, rt_used0, dst_used0;
  logic       rs_used1, rt_used1;
  logic       ld_rs_used, ld_dst_used;
  reg_idx_t   dst_reg0;
  logic [1:0] load_mask, dep_mask, issue_mask;
  logic       swap;
  inst_t      hold_next0, hold_next1;
  logic       is_load;

  ////////////////////////////////////////////////////////////////////////
  // slot selection and hazard chain
  ////////////////////////////////////////////////////////////////////////

  assign sel_inst0 = stall ? hold_inst0 : inst0;
  assign sel_inst1 = stall ? hold_inst1 : inst1;
  assign sel_pc0   = stall ? hold_pc0 : pc0;
  assign sel_pc1   = stall ? hold_pc1 : pc1;
  assign sel_id0   = stall ? hold_id0 : id0;
  assign sel_id1   = stall ? hold_id1 : id1;

  inst_classify u_classify0 (
    .inst(sel_inst0), .pipe(pipe0), .src_rs_used(rs_used0),
    .src_rt_used(rt_used0), .dst_used(dst_used0), .dst_reg(dst_reg0)
  );

  inst_classify u_classify1 (
    .inst(sel_inst1), .pipe(pipe1), .src_rs_used(rs_used1),
    .src_rt_used(rt_used1), .dst_used(), .dst_reg()
  );

  load_use_check u_load_use (
    .load_inst(last_load),
    .rs0(sel_inst0[rs_msb:rs_lsb]), .rt0(sel_inst0[rt_msb:rt_lsb]),
    .rs1(sel_inst1[rs_msb:rs_lsb]), .rt1(sel_inst1[rt_msb:rt_lsb]),
    .src_rs_used0(rs_used0), .src_rt_used0(rt_used0),
    .src_rs_used1(rs_used1), .src_rt_used1(rt_used1),
    .load_stall(), .mask(load_mask)
  );

  pair_dep_check u_pair_dep (
    .mask_in(load_mask), .dst_used0(dst_used0), .dst_reg0(dst_reg0),
    .rs1(sel_inst1[rs_msb:rs_lsb]), .rt1(sel_inst1[rt_msb:rt_lsb]),
    .src_rs_used1(rs_used1), .src_rt_used1(rt_used1), .mask_out(dep_mask)
  );

  pipe_steer u_steer (
    .mask_in(dep_mask), .pipe0(pipe0), .pipe1(pipe1),
    .mask_out(issue_mask), .swap(swap)
  );

  ////////////////////////////////////////////////////////////////////////
  // output crossbar
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_inst0 = '0;
    out_pc0   = '0;
    out_id0   = '0;
    out_inst1 = '0;
    out_pc1   = '0;
    out_id1   = '0;
    if (!flush) begin
      if (swap) begin
        if (issue_mask[1]) begin  // slot 1 to port 0.
          out_inst0 = sel_inst1;
          out_pc0   = sel_pc1;
          out_id0   = sel_id1;
        end
        if (issue_mask[0]) begin
          out_inst1 = sel_inst0;
          out_pc1   = sel_pc0;
          out_id1   = sel_id0;
        end
      end else begin
        if (issue_mask[0]) begin
          out_inst0 = sel_inst0;
          out_pc0   = sel_pc0;
          out_id0   = sel_id0;
        end
        if (issue_mask[1]) begin
          out_inst1 = sel_inst1;
          out_pc1   = sel_pc1;
          out_id1   = sel_id1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // hold, last-load and stall registers
  ////////////////////////////////////////////////////////////////////////

  // lw is the only memory op with a source and a destination.
  inst_classify u_classify_ld (
    .inst(out_inst1), .pipe(ld_pipe), .src_rs_used(ld_rs_used),
    .src_rt_used(), .dst_used(ld_dst_used), .dst_reg()
  );

  assign is_load    = (ld_pipe == pipe_mem) && ld_rs_used && ld_dst_used;
  assign hold_next0 = issue_mask[0] ? '0 : sel_inst0;
  assign hold_next1 = issue_mask[1] ? '0 : sel_inst1;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      hold_inst0 <= '0;
      hold_inst1 <= '0;
      last_load  <= '0;
      stall      <= 1'b0;
    end else begin
      hold_inst0 <= hold_next0;
      hold_inst1 <= hold_next1;
      last_load  <= is_load ? out_inst1 : '0;
      stall      <= (|hold_next0) || (|hold_next1);  // fetch repeats the pair.
    end
  end

  always_ff @(posedge clk) begin
    hold_pc0 <= issue_mask[0] ? '0 : sel_pc0;  // pc and id of the held slots.
    hold_id0 <= issue_mask[0] ? '0 : sel_id0;
    hold_pc1 <= issue_mask[1] ? '0 : sel_pc1;
    hold_id1 <= issue_mask[1] ? '0 : sel_id1;
  end

endmodule

`default_nettype wire

// File: bench/issue_properties.sv
`timescale 1ns/1ps
`default_nettype none

module issue_properties
  import issue_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  flush,
  input logic  stall,
  input inst_t out_inst0,
  input inst_t out_inst1
);

  stall_after_reset: assert property (@(posedge clk) reset |=> !stall)
    else $error("stall is high in the cycle after reset");

  flush_zeros_ports: assert property (@(posedge clk) disable iff (reset)
    flush |-> (out_inst0 == '0 && out_inst1 == '0))
    else $error("an issue port carries an instruction while flush is high");

  // port 0 is the branch pipe, port 1 the memory pipe.
  no_mem_on_port0: assert property (@(posedge clk) disable iff (reset)
    out_inst0[opcode_msb -: 2] != 2'b10)
    else $error("a memory op was steered to port 0");

  no_branch_on_port1: assert property (@(posedge clk) disable iff (reset)
    out_inst1[opcode_msb -: 2] != 2'b11)
    else $error("a branch op was steered to port 1");

endmodule

bind issue_stage issue_properties u_issue_properties (
  .clk(clk), .reset(reset), .flush(flush), .stall(stall),
  .out_inst0(out_inst0), .out_inst1(out_inst1)
);

`default_nettype wire

// File: bench/issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_tb
  import issue_pkg::*;
();

  localparam int clk_period  = 8;
  localparam int check_delay = 6;  // just before the next edge.
  localparam int n_rows      = 15;

  typedef enum logic [2:0] {
    ph_idle, ph_alu_pair, ph_swap, ph_mem_pair, ph_raw_split, ph_load_use, ph_flush
  } phase_t;

  typedef struct packed {
    inst_t inst;
    addr_t pc;
    iid_t  id;
  } slot_t;

  typedef struct packed {
    phase_t phase;
    logic   flush;
    slot_t  in0;
    slot_t  in1;
    logic   stall;
    slot_t  out0;
    slot_t  out1;
  } row_t;

  logic   clk, reset, flush, stall;
  inst_t  inst0, inst1, out_inst0, out_inst1;
  addr_t  pc0, pc1, out_pc0, out_pc1;
  iid_t   id0, id1, out_id0, out_id1;
  row_t   rows [n_rows];
  int     fill_idx;
  int     cur_row;
  phase_t cur_phase;

  issue_stage u_issue_stage (
    .clk(clk), .reset(reset), .flush(flush),
    .inst0(inst0), .inst1(inst1), .pc0(pc0), .pc1(pc1), .id0(id0), .id1(id1),
    .stall(stall),
    .out_inst0(out_inst0), .out_inst1(out_inst1),
    .out_pc0(out_pc0), .out_pc1(out_pc1), .out_id0(out_id0), .out_id1(out_id1)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  function automatic inst_t encode_inst(opcode_t op, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
    return {op, rs, rt, rd, 11'h000};
  endfunction

  function automatic slot_t pack_slot(inst_t inst, addr_t pc, iid_t id);
    return '{inst, pc, id};
  endfunction

  task automatic add_row(input phase_t ph, input logic fl, input slot_t in0, input slot_t in1,
                         input logic st, input slot_t out0, input slot_t out1);
    rows[fill_idx] = '{ph, fl, in0, in1, st, out0, out1};
    fill_idx++;
  endtask

  task automatic abort_run;
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_stall(input logic got, input logic want);
    if (got !== want) begin
      $display("ERROR: stall = %h, expected %h in %s row %0d",
               got, want, cur_phase.name(), cur_row);
      abort_run();
    end
  endtask

  task automatic check_slot(input int port, input inst_t got_inst, input addr_t got_pc,
                            input iid_t got_id, input slot_t want);
    if (got_inst !== want.inst) begin
      $display("ERROR: out_inst%0d = %h, expected %h in %s row %0d",
               port, got_inst, want.inst, cur_phase.name(), cur_row);
      abort_run();
    end else if (got_pc !== want.pc) begin
      $display("ERROR: out_pc%0d = %h, expected %h in %s row %0d",
               port, got_pc, want.pc, cur_phase.name(), cur_row);
      abort_run();
    end else if (got_id !== want.id) begin
      $display("ERROR: out_id%0d = %h, expected %h in %s row %0d",
               port, got_id, want.id, cur_phase.name(), cur_row);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // stimulus and expectation table
  ////////////////////////////////////////////////////////////////////////

  task automatic build_table;
    slot_t add_a, sub_b, addi_c, je_d, sw_e, add_f, lw_g, sw_h, add_i;
    slot_t sub_j, add_k, lw_l, add_m, sub_n, add_o, sub_p, addi_q, sw_r;
    add_a  = pack_slot(encode_inst(op_add, 5'd1, 5'd2, 5'd3), 32'h100, 4'd1);
    sub_b  = pack_slot(encode_inst(op_sub, 5'd4, 5'd5, 5'd6), 32'h104, 4'd2);
    addi_c = pack_slot(encode_inst(op_addi, 5'd1, 5'd7, 5'd0), 32'h108, 4'd3);
    je_d   = pack_slot(encode_inst(op_je, 5'd0, 5'd0, 5'd0), 32'h10c, 4'd4);
    sw_e   = pack_slot(encode_inst(op_sw, 5'd2, 5'd8, 5'd0), 32'h110, 4'd5);
    add_f  = pack_slot(encode_inst(op_add, 5'd9, 5'd10, 5'd11), 32'h114, 4'd6);
    lw_g   = pack_slot(encode_inst(op_lw, 5'd1, 5'd12, 5'd0), 32'h118, 4'd7);
    sw_h   = pack_slot(encode_inst(op_sw, 5'd2, 5'd13, 5'd0), 32'h11c, 4'd8);
    add_i  = pack_slot(encode_inst(op_add, 5'd1, 5'd2, 5'd14), 32'h120, 4'd9);
    sub_j  = pack_slot(encode_inst(op_sub, 5'd14, 5'd3, 5'd15), 32'h124, 4'd10);
    add_k  = pack_slot(encode_inst(op_add, 5'd1, 5'd2, 5'd16), 32'h128, 4'd11);
    lw_l   = pack_slot(encode_inst(op_lw, 5'd3, 5'd17, 5'd0), 32'h12c, 4'd12);
    add_m  = pack_slot(encode_inst(op_add, 5'd17, 5'd4, 5'd18), 32'h130, 4'd13);
    sub_n  = pack_slot(encode_inst(op_sub, 5'd5, 5'd6, 5'd19), 32'h134, 4'd14);
    add_o  = pack_slot(encode_inst(op_add, 5'd1, 5'd2, 5'd20), 32'h138, 4'd15);
    sub_p  = pack_slot(encode_inst(op_sub, 5'd20, 5'd3, 5'd21), 32'h13c, 4'd0);
    addi_q = pack_slot(encode_inst(op_addi, 5'd1, 5'd22, 5'd0), 32'h140, 4'd1);
    sw_r   = pack_slot(encode_inst(op_sw, 5'd2, 5'd23, 5'd0), 32'h144, 4'd2);
    fill_idx = 0;
    //      phase         flush  slot 0  slot 1  stall  port 0  port 1
    add_row(ph_idle,      1'b0,  '0,     '0,     1'b0,  '0,     '0);
    add_row(ph_alu_pair,  1'b0,  add_a,  sub_b,  1'b0,  add_a,  sub_b);
    add_row(ph_swap,      1'b0,  addi_c, je_d,   1'b0,  je_d,   addi_c);  // branch to port 0.
    add_row(ph_swap,      1'b0,  sw_e,   add_f,  1'b0,  add_f,  sw_e);    // memory to port 1.
    add_row(ph_mem_pair,  1'b0,  lw_g,   sw_h,   1'b0,  '0,     lw_g);
    add_row(ph_mem_pair,  1'b0,  lw_g,   sw_h,   1'b1,  '0,     sw_h);
    add_row(ph_raw_split, 1'b0,  add_i,  sub_j,  1'b0,  add_i,  '0);
    add_row(ph_raw_split, 1'b0,  add_i,  sub_j,  1'b1,  '0,     sub_j);
    add_row(ph_load_use,  1'b0,  add_k,  lw_l,   1'b0,  add_k,  lw_l);
    add_row(ph_load_use,  1'b0,  add_m,  sub_n,  1'b0,  '0,     '0);      // reads r17.
    add_row(ph_load_use,  1'b0,  add_m,  sub_n,  1'b1,  add_m,  sub_n);
    add_row(ph_flush,     1'b0,  add_o,  sub_p,  1'b0,  add_o,  '0);
    add_row(ph_flush,     1'b1,  add_o,  sub_p,  1'b1,  '0,     '0);
    add_row(ph_flush,     1'b0,  addi_q, sw_r,   1'b0,  addi_q, sw_r);
    add_row(ph_idle,      1'b0,  '0,     '0,     1'b0,  '0,     '0);
  endtask

  initial begin : stimulus
    reset     <= 1'b1;
    flush     <= 1'b0;
    inst0     <= '0;
    inst1     <= '0;
    pc0       <= '0;
    pc1       <= '0;
    id0       <= '0;
    id1       <= '0;
    cur_phase <= ph_idle;
    build_table();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    for (cur_row = 0; cur_row < n_rows; cur_row++) begin
      @(posedge clk);
      cur_phase <= rows[cur_row].phase;
      flush     <= rows[cur_row].flush;
      inst0     <= rows[cur_row].in0.inst;
      pc0       <= rows[cur_row].in0.pc;
      id0       <= rows[cur_row].in0.id;
      inst1     <= rows[cur_row].in1.inst;
      pc1       <= rows[cur_row].in1.pc;
      id1       <= rows[cur_row].in1.id;
      #check_delay;
      check_stall(stall, rows[cur_row].stall);
      check_slot(0, out_inst0, out_pc0, out_id0, rows[cur_row].out0);
      check_slot(1, out_inst1, out_pc1, out_id1, rows[cur_row].out1);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin : watchdog
    #((n_rows + 20) * clk_period);
    $display("timeout: the stimulus table did not finish within %0d ns",
             (n_rows + 20) * clk_period);
    abort_run();
  end

endmodule

`default_nettype wire

// File: build.f
hw/issue_pkg.sv
hw/inst_classify.sv
hw/load_use_check.sv
hw/pair_dep_check.sv
hw/pipe_steer.sv
hw/issue_stage.sv
bench/issue_properties.sv
bench/issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the issue stage testbench with Verilator, run it, and look for the pass line.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module issue_tb -o issue_sim
sim_out=$(./obj_dir/issue_sim || true)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS"
echo "simulation passed"
